/* hw/alu_apb_regs.sv */
`timescale 1ns/1ns

module alu_apb_regs (
    input  logic        clk,
    input  logic        rst,
    // APB slave
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // To decoder and ALU
    output logic [31:0] instr,
    output logic [31:0] pc,
    output logic [31:0] rs1,
    output logic [31:0] rs2,
    output logic [31:0] accuracy,
    output logic        start,
    // From ALU and decoder
    input  logic [31:0] result,
    input  logic        done,
    input  logic        illegal
);

    import alu_pkg::*;

    logic        access;                             // APB access phase
    logic        addr_ok;                            // Mapped offset
    logic        rd_wait;                            // Read that needs a fresh result
    logic        stall;
    logic        wr_done;                            // Write completes this edge
    logic        busy;
    logic        st_illegal;
    logic [31:0] status;

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------
    assign access  = psel & penable;
    assign addr_ok = (paddr == REG_PC)     || (paddr == REG_RS1)    ||
                     (paddr == REG_RS2)    || (paddr == REG_ACC)    ||
                     (paddr == REG_INSTR)  || (paddr == REG_RESULT) ||
                     (paddr == REG_STATUS);
    assign rd_wait = ~pwrite & ((paddr == REG_RESULT) || (paddr == REG_STATUS));
    assign stall   = busy & (pwrite | rd_wait);    // Held until busy clears
    assign pready  = access & ~stall;
    assign wr_done = pready & pwrite;
    assign pslverr = pready & (~addr_ok |
                     (~pwrite & (paddr == REG_RESULT) & st_illegal));

    // ------------------------------------------------------------
    // Writable registers and start
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            rs1      <= '0;
            rs2      <= '0;
            accuracy <= '0;
            instr    <= '0;
        end else if (wr_done) begin
            case (paddr)
                REG_PC:    pc       <= pwdata;
                REG_RS1:   rs1      <= pwdata;
                REG_RS2:   rs2      <= pwdata;
                REG_ACC:   accuracy <= pwdata;
                REG_INSTR: instr    <= pwdata;
                default:   ;                         // Read-only or unmapped
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start      <= 1'b0;
            busy       <= 1'b0;
            st_illegal <= 1'b0;
        end else begin
            start <= wr_done & (paddr == REG_INSTR); // Single cycle pulse
            if (wr_done && paddr == REG_INSTR)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
            if (start)
                st_illegal <= illegal;               // Decode of the new word
        end
    end

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        status             = '0;
        status[ST_BUSY]    = busy;
        status[ST_ILLEGAL] = st_illegal;
    end

    always_comb begin
        case (paddr)
            REG_PC:     prdata = pc;
            REG_RS1:    prdata = rs1;
            REG_RS2:    prdata = rs2;
            REG_ACC:    prdata = accuracy;
            REG_INSTR:  prdata = instr;
            REG_RESULT: prdata = result;
            REG_STATUS: prdata = status;
            default:    prdata = '0;
        endcase
    end

endmodule

/* hw/alu_apb_top.sv */
`timescale 1ns/1ns

module alu_apb_top #(
    parameter int XLEN    = 32,
    parameter int APX_LEN = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    import alu_pkg::*;

    logic [31:0]     instr;                          // Register block outputs
    logic [31:0]     pc;
    logic [31:0]     rs1;
    logic [31:0]     rs2;
    logic [31:0]     accuracy;
    logic            start;
    logic [XLEN-1:0] result;                         // ALU outputs
    logic            done;
    alu_op_e         op;                             // Decoder outputs
    logic [31:0]     imm;
    logic            use_pc;
    logic            use_imm;
    logic            illegal;

    alu_apb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .instr    (instr),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .accuracy (accuracy),
        .start    (start),
        .result   (result),
        .done     (done),
        .illegal  (illegal)
    );

    instr_decoder u_dec (
        .instr   (instr),                            // Viewed through instr_u
        .op      (op),
        .imm     (imm),
        .use_pc  (use_pc),
        .use_imm (use_imm),
        .illegal (illegal)
    );

    arithmetic_logic_unit #(
        .XLEN    (XLEN),
        .APX_LEN (APX_LEN)
    ) u_alu (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .use_pc   (use_pc),
        .use_imm  (use_imm),
        .imm      (imm),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .accuracy (accuracy),
        .illegal  (illegal),
        .result   (result),
        .done     (done)
    );

endmodule

/* hw/alu_pkg.sv */
package alu_pkg;

    // ------------------------------------------------------------
    // RV32I major opcodes handled by the unit
    // ------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b01_100_11;   // R-type arithmetic
    localparam logic [6:0] OPC_OP_IMM = 7'b00_100_11;   // I-type arithmetic
    localparam logic [6:0] OPC_JAL    = 7'b11_011_11;
    localparam logic [6:0] OPC_JALR   = 7'b11_001_11;
    localparam logic [6:0] OPC_AUIPC  = 7'b00_101_11;

    // ------------------------------------------------------------
    // Operation code from decoder to ALU
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ADD,                                             // Also ADDI
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PC_LINK,                                         // PC + 4 for JAL and JALR
        PC_IMM                                           // PC + U immediate
    } alu_op_e;

    // Three field layouts over one instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;                                             // Register-register
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;                                             // Register-immediate
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;                                             // Upper immediate
    } instr_u;

    // ------------------------------------------------------------
    // APB register map
    // ------------------------------------------------------------
    localparam logic [7:0] REG_PC     = 8'h00;
    localparam logic [7:0] REG_RS1    = 8'h04;
    localparam logic [7:0] REG_RS2    = 8'h08;
    localparam logic [7:0] REG_ACC    = 8'h0C;           // Accuracy control word
    localparam logic [7:0] REG_INSTR  = 8'h10;           // Write starts an operation
    localparam logic [7:0] REG_RESULT = 8'h14;           // Read only
    localparam logic [7:0] REG_STATUS = 8'h18;           // Read only

    localparam int ST_BUSY    = 0;                       // Status bit positions
    localparam int ST_ILLEGAL = 1;

endpackage

/* hw/approx_adder.sv */
`timescale 1ns/1ns

module approx_adder #(
    parameter int LEN     = 32,
    parameter int APX_LEN = 8
) (
    input  logic [LEN-1:0]     a,
    input  logic [LEN-1:0]     b,
    input  logic               cin,
    input  logic [APX_LEN-1:0] er,                    // Per-bit approximate enable
    output logic [LEN-1:0]     sum,
    output logic               cout
);

    logic [LEN:0]   carry;                            // Ripple chain, carry[0] is cin
    logic [LEN-1:0] prop;                             // Half-sum per bit
    logic [LEN-1:0] gen;                              // Generate per bit

    assign carry[0] = cin;
    assign prop     = a ^ b;
    assign gen      = a & b;

    // ------------------------------------------------------------
    // Low bits, each one able to cut the chain
    // ------------------------------------------------------------
    genvar k;
    for (k = 0; k < LEN; k++) begin : g_bit
        if (k < APX_LEN) begin : g_apx
            always_comb begin
                if (er[k]) begin
                    sum[k]     = prop[k];             // Carry-in ignored
                    carry[k+1] = gen[k];              // Carry from operands only
                end else begin
                    sum[k]     = prop[k] ^ carry[k];  // Exact full adder
                    carry[k+1] = gen[k] | (prop[k] & carry[k]);
                end
            end
        end else begin : g_exact
            // Upper bits always exact
            assign sum[k]     = prop[k] ^ carry[k];
            assign carry[k+1] = gen[k] | (prop[k] & carry[k]);
        end
    end

    assign cout = carry[LEN];                         // Final carry out

endmodule

/* hw/arithmetic_logic_unit.sv */
`timescale 1ns/1ns

module arithmetic_logic_unit #(
    parameter int XLEN    = 32,
    parameter int APX_LEN = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,                  // One-cycle launch
    input  alu_pkg::alu_op_e op,
    input  logic             use_pc,
    input  logic             use_imm,
    input  logic [XLEN-1:0]  imm,
    input  logic [XLEN-1:0]  pc,
    input  logic [XLEN-1:0]  rs1,
    input  logic [XLEN-1:0]  rs2,
    input  logic [31:0]      accuracy,               // Accuracy control word
    input  logic             illegal,
    output logic [XLEN-1:0]  result,
    output logic             done
);

    import alu_pkg::*;

    // Stage one signals
    logic [XLEN-1:0]    op1_d;
    logic [XLEN-1:0]    op2_d;
    logic [APX_LEN-1:0] er_d;
    logic [XLEN-1:0]    op1_q;
    logic [XLEN-1:0]    op2_q;
    logic [APX_LEN-1:0] er_q;
    alu_op_e            op_q;
    logic               illegal_q;
    logic               valid_q;                     // Stage one holds an op

    // Stage two signals
    logic [XLEN-1:0]    add_b;
    logic               add_cin;
    logic [XLEN-1:0]    add_sum;
    logic [XLEN-1:0]    res_d;
    logic [4:0]         shamt;

    // ------------------------------------------------------------
    // Operand multiplexers
    // ------------------------------------------------------------
    assign op1_d = use_pc ? pc : rs1;                // PC for jumps and AUIPC

    always_comb begin
        if (op == PC_LINK)
            op2_d = XLEN'(4);                        // Link offset
        else if (use_imm)
            op2_d = imm;
        else
            op2_d = rs2;
    end

    // Bit k from accuracy[k+2], bit 0 also from accuracy[0]
    assign er_d = accuracy[APX_LEN+1:2] | APX_LEN'(accuracy[0]);

    // ------------------------------------------------------------
    // Stage one registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            op1_q     <= op1_d;
            op2_q     <= op2_d;
            er_q      <= er_d;
            op_q      <= op;
            illegal_q <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;                        // Follows start by one edge
        end
    end

    // ------------------------------------------------------------
    // Adder and result select
    // ------------------------------------------------------------
    assign add_cin = (op_q == SUB);                  // Two's complement subtract
    assign add_b   = add_cin ? ~op2_q : op2_q;
    assign shamt   = op2_q[4:0];

    approx_adder #(
        .LEN     (XLEN),
        .APX_LEN (APX_LEN)
    ) u_adder (
        .a    (op1_q),
        .b    (add_b),
        .cin  (add_cin),
        .er   (er_q),
        .sum  (add_sum),
        .cout ()                                     // Carry out not needed
    );

    always_comb begin
        case (op_q)
            ADD, SUB, PC_LINK, PC_IMM: res_d = add_sum;
            SLL:  res_d = op1_q << shamt;
            SLT:  res_d = XLEN'($signed(op1_q) < $signed(op2_q));
            SLTU: res_d = XLEN'(op1_q < op2_q);
            XOR:  res_d = op1_q ^ op2_q;
            SRL:  res_d = op1_q >> shamt;
            SRA:  res_d = $unsigned($signed(op1_q) >>> shamt); // Sign fill
            OR:   res_d = op1_q | op2_q;
            AND:  res_d = op1_q & op2_q;
            default: res_d = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Stage two register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= valid_q;                         // Two edges after start
            if (valid_q)
                result <= illegal_q ? '0 : res_d;    // Zero on illegal word
        end
    end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  alu_pkg::instr_u  instr,
    output alu_pkg::alu_op_e op,
    output logic [31:0]      imm,
    output logic             use_pc,                   // Operand 1 is PC
    output logic             use_imm,                  // Operand 2 is imm
    output logic             illegal
);

    import alu_pkg::*;

    logic f7_base;                                     // funct7 all zero
    logic f7_alt;                                      // funct7 of SUB and SRA

    assign f7_base = (instr.r.funct7 == 7'b000_0000);
    assign f7_alt  = (instr.r.funct7 == 7'b010_0000);

    always_comb begin
        op      = ADD;                                 // Defaults
        imm     = '0;
        use_pc  = 1'b0;
        use_imm = 1'b0;
        illegal = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin                              // R view
                case (instr.r.funct3)
                    3'b000:  op = f7_alt ? SUB : ADD;
                    3'b001:  op = SLL;
                    3'b010:  op = SLT;
                    3'b011:  op = SLTU;
                    3'b100:  op = XOR;
                    3'b101:  op = f7_alt ? SRA : SRL;
                    3'b110:  op = OR;
                    default: op = AND;
                endcase
                // Alternate funct7 only legal for SUB and SRA
                illegal = ~(f7_base | (f7_alt & (instr.r.funct3 == 3'b000 ||
                                                 instr.r.funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin                          // I view
                imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                use_imm = 1'b1;
                case (instr.i.funct3)
                    3'b000:  op = ADD;
                    3'b001: begin
                        op      = SLL;
                        illegal = ~f7_base;            // SLLI shamt upper bits
                    end
                    3'b010:  op = SLT;
                    3'b011:  op = SLTU;
                    3'b100:  op = XOR;
                    3'b101: begin
                        op      = f7_alt ? SRA : SRL;
                        illegal = ~(f7_base | f7_alt);
                    end
                    3'b110:  op = OR;
                    default: op = AND;
                endcase
            end
            OPC_JALR: begin
                imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                op      = PC_LINK;
                use_pc  = 1'b1;
                illegal = (instr.i.funct3 != 3'b000);
            end
            OPC_JAL: begin
                op     = PC_LINK;                      // Link value only
                use_pc = 1'b1;
            end
            OPC_AUIPC: begin                           // U view
                imm     = {instr.u.imm20, 12'h000};
                op      = PC_IMM;
                use_pc  = 1'b1;
                use_imm = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module alu_tb \
    -f vlog.f \
    -o alu_sim

./obj_dir/alu_sim

/* verif/alu_checker.sv */
`timescale 1ns/1ns

module alu_checker (
    input logic       clk,
    input logic       rst,
    input logic [7:0] paddr,
    input logic       psel,
    input logic       penable,
    input logic       pwrite,
    input logic       start,
    input logic       done
);

    // Address and direction held from setup through access
    a_stable_access: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> ($stable(paddr) && $stable(pwrite)))
        else $error("paddr or pwrite changed during an APB access phase");

    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        start |=> !start)                                 // One cycle wide
        else $error("start held high for more than one cycle");

    // Done exactly two edges after start, never otherwise
    a_done_delay: assert property (@(posedge clk) disable iff (rst)
        done == $past(start, 2))
        else $error("done does not follow start by exactly two cycles");

endmodule

bind alu_apb_regs alu_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .start   (start),
    .done    (done)
);

/* verif/alu_tb.sv */
`timescale 1ns/1ns

module alu_tb;

    import alu_pkg::*;

    localparam int TIMEOUT = 50;                          // Max wait cycles per transfer

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        xfer_done;                               // Transfer completed at last edge
    logic [31:0] xfer_data;
    logic        xfer_err;

    alu_apb_top #(.XLEN(32), .APX_LEN(8)) DUT (.*);

    always #20 clk = ~clk;                                // 40 ns period

    // Completion monitor, samples like a flop
    always @(posedge clk) begin
        xfer_done <= psel & penable & pready;
        xfer_data <= prdata;
        xfer_err  <= pslverr;
    end

    // ----------------------------------------------------------
    // Error reporting and compare tasks
    // ----------------------------------------------------------
    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: illegal/busy got %b, expected %b", what, got, exp));
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: pslverr got %b, expected %b", what, got, exp));
    endtask

    // ----------------------------------------------------------
    // APB driver
    // ----------------------------------------------------------
    task automatic finish_transfer(output int waits);
        waits = 0;
        @(negedge clk);
        penable = 1'b1;                                   // Access phase
        do begin
            @(negedge clk);
            if (!xfer_done)
                waits++;
            if (waits > TIMEOUT) begin
                $display("Timeout: the DUT never raised pready");
                $display("** FAIL **");
                $fatal(1, "APB transfer timed out");
            end
        end while (!xfer_done);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        int waits;
        @(negedge clk);
        paddr  = addr;                                    // Setup phase
        pwrite = 1'b1;
        pwdata = data;
        psel   = 1'b1;
        finish_transfer(waits);
        err = xfer_err;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err,
                            output int waits);
        @(negedge clk);
        paddr  = addr;
        pwrite = 1'b0;
        psel   = 1'b1;
        finish_transfer(waits);
        data = xfer_data;
        err  = xfer_err;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_err(err, 1'b0, $sformatf("write to %h", addr));
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] approx_add(input logic [31:0] a, input logic [31:0] b,
                                               input logic cin, input logic [31:0] acc);
        logic [7:0]  er;
        logic [31:0] s;
        logic        c;
        logic        cut;
        er = acc[9:2] | {7'b0, acc[0]};                   // Bit k from acc[k+2], bit 0 also acc[0]
        c  = cin;
        for (int k = 0; k < 32; k++) begin
            cut  = (k < 8) ? er[k[2:0]] : 1'b0;
            s[k] = a[k] ^ b[k] ^ (cut ? 1'b0 : c);        // Cut bit drops its carry-in
            c    = cut ? (a[k] & b[k]) : ((a[k] & b[k]) | ((a[k] ^ b[k]) & c));
        end
        return s;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [31:0] iw, input logic [31:0] pcv,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] acc, output logic ill);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        alt;
        logic [31:0] op2;
        logic [31:0] r;
        opc = iw[6:0];
        f3  = iw[14:12];
        f7  = iw[31:25];
        alt = (f7 == 7'h20);
        op2 = (opc == OPC_OP) ? b : {{20{iw[31]}}, iw[31:20]};
        r   = '0;
        ill = 1'b0;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                if (opc == OPC_OP)                        // 0x20 only on SUB and SRA
                    ill = (f7 != 7'h00) && !(alt && (f3 == 3'd0 || f3 == 3'd5));
                else if (f3 == 3'd1)
                    ill = (f7 != 7'h00);                  // SLLI
                else if (f3 == 3'd5)
                    ill = (f7 != 7'h00) && !alt;          // SRLI and SRAI
                case (f3)
                    3'd0: r = (opc == OPC_OP && alt) ? approx_add(a, ~op2, 1'b1, acc)
                                                     : approx_add(a, op2, 1'b0, acc);
                    3'd1: r = a << op2[4:0];
                    3'd2: r = {31'b0, $signed(a) < $signed(op2)};
                    3'd3: r = {31'b0, a < op2};
                    3'd4: r = a ^ op2;
                    3'd5: r = alt ? $unsigned($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                    3'd6: r = a | op2;
                    default: r = a & op2;
                endcase
            end
            OPC_JAL: r = approx_add(pcv, 32'd4, 1'b0, acc);   // Link value
            OPC_JALR: begin
                ill = (f3 != 3'd0);
                r   = approx_add(pcv, 32'd4, 1'b0, acc);
            end
            OPC_AUIPC: r = approx_add(pcv, {iw[31:12], 12'h000}, 1'b0, acc);
            default: ill = 1'b1;
        endcase
        return ill ? 32'h0 : r;                           // Zero on illegal word
    endfunction

    // ----------------------------------------------------------
    // Instruction encoders
    // ----------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    function automatic logic [31:0] rand_legal();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3  = 3'($urandom);
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
        imm = 12'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5)
            imm[11:5] = f7;                               // Shift immediates carry funct7
        if ($urandom_range(0, 1))
            return enc_r(f7, f3);
        return enc_i(imm, f3, OPC_OP_IMM);
    endfunction

    // Load operands, launch, read back result and status
    task automatic run_op(input logic [31:0] iw, input logic [31:0] pcv, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] acc, output logic [31:0] got);
        logic [31:0] exp;
        logic [31:0] st;
        logic        ill;
        logic        err;
        int          waits;
        exp = ref_alu(iw, pcv, a, b, acc, ill);
        write_reg(REG_PC, pcv);
        write_reg(REG_RS1, a);
        write_reg(REG_RS2, b);
        write_reg(REG_ACC, acc);
        write_reg(REG_INSTR, iw);
        apb_read(REG_RESULT, got, err, waits);            // Issued while still busy
        if (waits == 0)
            report_error("result read right after start was not stalled");
        check_err(err, ill, "result read");
        check_word(got, exp, $sformatf("result of %h", iw));
        apb_read(REG_STATUS, st, err, waits);
        check_err(err, 1'b0, "status read");
        check_status(st[1:0], {ill, 1'b0}, "status after op");
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        logic [31:0] iw;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] acc;
        logic [31:0] got;
        logic        err;
        int          waits;
        void'($urandom(19059));                           // Fixed seed
        clk     = 1'b0;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apb_read(REG_STATUS, got, err, waits);            // Idle after reset
        check_status(got[1:0], 2'b00, "status after reset");

        // Register write then read
        for (int n = 0; n < 8; n++) begin
            for (int r = 0; r < 4; r++) begin
                iw = $urandom;
                write_reg(8'(r * 4), iw);                 // PC, RS1, RS2, ACC
                apb_read(8'(r * 4), got, err, waits);
                check_err(err, 1'b0, "register read");
                check_word(got, iw, "register readback");
            end
        end

        // Exact unit, all legal OP and OP_IMM words
        for (int n = 0; n < 200; n++)
            run_op(rand_legal(), $urandom, $urandom, $urandom, 32'h0, got);

        // Approximate ADD, SUB and ADDI
        for (int n = 0; n < 150; n++) begin
            case (n % 3)
                0: iw = enc_r(7'h00, 3'd0);
                1: iw = enc_r(7'h20, 3'd0);
                default: iw = enc_i(12'($urandom), 3'd0, OPC_OP_IMM);
            endcase
            run_op(iw, $urandom, $urandom, $urandom, $urandom, got);
        end

        // No carry generated in the low byte, exact sum expected
        for (int n = 0; n < 40; n++) begin
            a      = $urandom;
            b      = $urandom;
            b[7:0] = b[7:0] & ~a[7:0];
            run_op(enc_r(7'h00, 3'd0), $urandom, a, b, $urandom, got);
            check_word(got, a + b, "no-carry add");
        end

        // Jumps and AUIPC, exact then approximate
        for (int n = 0; n < 60; n++) begin
            acc = (n < 30) ? 32'h0 : 32'($urandom);
            case (n % 3)
                0: iw = {20'($urandom), 5'($urandom), OPC_JAL};
                1: iw = enc_i(12'($urandom), 3'd0, OPC_JALR);
                default: iw = {20'($urandom), 5'($urandom), OPC_AUIPC};
            endcase
            run_op(iw, $urandom, $urandom, $urandom, acc, got);
        end

        // Illegal words, then a legal one clears the flag
        run_op(enc_r(7'h01, 3'd0), $urandom, $urandom, $urandom, 32'h0, got);   // MUL
        run_op(enc_r(7'h20, 3'd4), $urandom, $urandom, $urandom, 32'h0, got);
        run_op(enc_i(12'h400, 3'd1, OPC_OP_IMM), 32'h0, $urandom, 32'h0, 32'h0, got);
        run_op(enc_i(12'hFE5, 3'd5, OPC_OP_IMM), 32'h0, $urandom, 32'h0, 32'h0, got);
        run_op(enc_i(12'h010, 3'd2, OPC_JALR), $urandom, 32'h0, 32'h0, 32'h0, got);
        run_op({25'($urandom), 7'b0000011}, $urandom, $urandom, $urandom, 32'h0, got);
        run_op({25'($urandom), 7'b1100011}, $urandom, $urandom, $urandom, 32'h0, got);
        run_op(rand_legal(), $urandom, $urandom, $urandom, 32'h0, got);

        // Unmapped offsets
        apb_read(8'h1C, got, err, waits);
        check_err(err, 1'b1, "read of unmapped 0x1C");
        apb_read(8'h02, got, err, waits);
        check_err(err, 1'b1, "read of unmapped 0x02");
        apb_write(8'h24, $urandom, err);
        check_err(err, 1'b1, "write to unmapped 0x24");

        $display("** PASS **");
        $finish;
    end

endmodule

/* vlog.f */
hw/alu_pkg.sv
hw/approx_adder.sv
hw/instr_decoder.sv
hw/arithmetic_logic_unit.sv
hw/alu_apb_regs.sv
hw/alu_apb_top.sv
verif/alu_checker.sv
verif/alu_tb.sv
